/* src/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // One machine word
  localparam int xlen = 32;

  // Register index, x0 to x31
  typedef logic [4:0] reg_addr_t;

  // ----------------------------------------
  // Major opcodes
  // ----------------------------------------
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  // ----------------------------------------
  // funct3 for OP and OP-IMM
  // ----------------------------------------
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // funct3 for conditional branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // Selects SUB and SRA/SRAI
  localparam logic [6:0] funct7_alt = 7'b0100000;

  // Whole instruction words
  localparam logic [31:0] instr_ebreak = 32'h0010_0073;
  localparam logic [31:0] instr_nop    = 32'h0000_0013;

endpackage

`default_nettype wire

/* src/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

  // Shift amount field of the ALU B operand
  localparam int shamt_w = 5;

  // ----------------------------------------
  // ALU operations, already resolved
  // ----------------------------------------
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_sra
  } alu_op_t;

  // Immediate formats
  typedef enum logic [2:0] {
    fmt_i,
    fmt_s,
    fmt_b,
    fmt_u,
    fmt_j
  } imm_sel_t;

  // ALU operand A source
  typedef enum logic [1:0] {
    a_rs1,
    a_zero,
    a_pc
  } alu_a_sel_t;

  // Write-back source
  typedef enum logic [1:0] {
    res_alu,
    res_load,
    res_pc4
  } res_sel_t;

endpackage

`default_nettype wire

/* src/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  logic [31:0]    instr,
  output reg_addr_t      rs1,
  output reg_addr_t      rs2,
  output reg_addr_t      rd,
  output logic           reg_write,
  output logic           mem_write,
  output alu_a_sel_t     alu_a_sel,
  output logic           alu_b_imm,
  output alu_op_t        alu_op,
  output res_sel_t       res_sel,
  output logic           is_branch,
  output logic           is_jump,
  output logic           jump_reg,
  output logic [2:0]     funct3,
  output logic [xlen-1:0] imm
);

  logic [6:0]      opcode;
  logic [6:0]      funct7;
  logic            alt;
  alu_op_t         alu_op_arith;
  imm_sel_t        imm_sel;
  logic [xlen-1:0] imm_i_val;
  logic [xlen-1:0] imm_s_val;
  logic [xlen-1:0] imm_b_val;
  logic [xlen-1:0] imm_u_val;
  logic [xlen-1:0] imm_j_val;

  // ----------------------------------------
  // Field extraction
  // ----------------------------------------
  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];
  assign alt    = (funct7 == funct7_alt);

  // Immediate formats, all sign extended except U
  assign imm_i_val = {{20{instr[31]}}, instr[31:20]};
  assign imm_s_val = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b_val = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u_val = {instr[31:12], 12'b0};
  assign imm_j_val = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (imm_sel)
      fmt_s:   imm = imm_s_val;
      fmt_b:   imm = imm_b_val;
      fmt_u:   imm = imm_u_val;
      fmt_j:   imm = imm_j_val;
      default: imm = imm_i_val;
    endcase
  end

  // ----------------------------------------
  // ALU operation from funct3/funct7
  // ----------------------------------------
  // SUB exists only in the register form, ADDI has no alternate
  always_comb begin
    case (funct3)
      f3_add:  alu_op_arith = (alt && opcode == op_reg) ? alu_sub : alu_add;
      f3_sll:  alu_op_arith = alu_sll;
      f3_slt:  alu_op_arith = alu_slt;
      f3_sltu: alu_op_arith = alu_sltu;
      f3_xor:  alu_op_arith = alu_xor;
      f3_sr:   alu_op_arith = alt ? alu_sra : alu_srl;
      f3_or:   alu_op_arith = alu_or;
      f3_and:  alu_op_arith = alu_and;
      default: alu_op_arith = alu_add;
    endcase
  end

  // ----------------------------------------
  // Control word
  // ----------------------------------------
  always_comb begin
    // Defaults give a NOP
    reg_write = 1'b0;
    mem_write = 1'b0;
    alu_a_sel = a_rs1;
    alu_b_imm = 1'b0;
    alu_op    = alu_add;
    res_sel   = res_alu;
    is_branch = 1'b0;
    is_jump   = 1'b0;
    jump_reg  = 1'b0;
    imm_sel   = fmt_i;

    case (opcode)
      op_lui: begin
        reg_write = 1'b1;
        alu_a_sel = a_zero;
        alu_b_imm = 1'b1;
        imm_sel   = fmt_u;
      end
      op_auipc: begin
        reg_write = 1'b1;
        alu_a_sel = a_pc;
        alu_b_imm = 1'b1;
        imm_sel   = fmt_u;
      end
      op_jal: begin
        reg_write = 1'b1;
        res_sel   = res_pc4;
        is_jump   = 1'b1;
        imm_sel   = fmt_j;
      end
      op_jalr: begin
        // ALU forms rs1 + imm for the target
        reg_write = 1'b1;
        res_sel   = res_pc4;
        is_jump   = 1'b1;
        jump_reg  = 1'b1;
        alu_b_imm = 1'b1;
      end
      op_branch: begin
        is_branch = 1'b1;
        imm_sel   = fmt_b;
      end
      op_load: begin
        reg_write = 1'b1;
        alu_b_imm = 1'b1;
        res_sel   = res_load;
      end
      op_store: begin
        mem_write = 1'b1;
        alu_b_imm = 1'b1;
        imm_sel   = fmt_s;
      end
      op_imm: begin
        reg_write = 1'b1;
        alu_b_imm = 1'b1;
        alu_op    = alu_op_arith;
      end
      op_reg: begin
        reg_write = 1'b1;
        alu_op    = alu_op_arith;
      end
      // EBREAK is caught at the top, nothing to do here
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
  import rv_isa_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n,
  input  reg_addr_t       rs1_addr,
  output logic [xlen-1:0] rs1_data,
  input  reg_addr_t       rs2_addr,
  output logic [xlen-1:0] rs2_data,
  input  logic            rd_en,
  input  reg_addr_t       rd_addr,
  input  logic [xlen-1:0] rd_data
);

  // x1 to x31, x0 has no storage
  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_en && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // Combinational read ports
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* src/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  input  logic [xlen-1:0] imm,
  input  alu_a_sel_t      alu_a_sel,
  input  logic            alu_b_imm,
  input  alu_op_t         alu_op,
  input  logic            is_branch,
  input  logic            is_jump,
  input  logic            jump_reg,
  input  logic [2:0]      funct3,
  output logic [xlen-1:0] alu_result,
  output logic            pc_redirect,
  output logic [xlen-1:0] target
);

  logic [xlen-1:0]    alu_a;
  logic [xlen-1:0]    alu_b;
  logic [shamt_w-1:0] shamt;
  logic               rs_eq;
  logic               rs_lt_s;
  logic               rs_lt_u;
  logic               branch_taken;

  // ----------------------------------------
  // Operand selection
  // ----------------------------------------
  always_comb begin
    case (alu_a_sel)
      a_pc:    alu_a = pc;
      a_zero:  alu_a = '0;
      default: alu_a = rs1_data;
    endcase
  end

  assign alu_b = alu_b_imm ? imm : rs2_data;
  assign shamt = alu_b[shamt_w-1:0];

  // ----------------------------------------
  // ALU
  // ----------------------------------------
  always_comb begin
    case (alu_op)
      alu_sub:  alu_result = alu_a - alu_b;
      alu_and:  alu_result = alu_a & alu_b;
      alu_or:   alu_result = alu_a | alu_b;
      alu_xor:  alu_result = alu_a ^ alu_b;
      alu_slt:  alu_result = {{(xlen-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      alu_sltu: alu_result = {{(xlen-1){1'b0}}, alu_a < alu_b};
      alu_sll:  alu_result = alu_a << shamt;
      alu_srl:  alu_result = alu_a >> shamt;
      alu_sra:  alu_result = $unsigned($signed(alu_a) >>> shamt);
      default:  alu_result = alu_a + alu_b;
    endcase
  end

  // ----------------------------------------
  // Branch comparison
  // ----------------------------------------
  assign rs_eq   = (rs1_data == rs2_data);
  assign rs_lt_s = ($signed(rs1_data) < $signed(rs2_data));
  assign rs_lt_u = (rs1_data < rs2_data);

  always_comb begin
    case (funct3)
      f3_beq:  branch_taken = rs_eq;
      f3_bne:  branch_taken = !rs_eq;
      f3_blt:  branch_taken = rs_lt_s;
      f3_bge:  branch_taken = !rs_lt_s;
      f3_bltu: branch_taken = rs_lt_u;
      f3_bgeu: branch_taken = !rs_lt_u;
      default: branch_taken = 1'b0;
    endcase
  end

  assign pc_redirect = is_jump || (is_branch && branch_taken);

  // JALR target comes from the ALU sum, forced even
  assign target = jump_reg ? {alu_result[xlen-1:1], 1'b0} : pc + imm;

endmodule

`default_nettype wire

/* src/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
#(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic            clk,
  input  logic            arst_n,
  output logic [xlen-1:0] imem_raddr,
  input  logic [xlen-1:0] imem_rdata,
  output logic [xlen-1:0] dmem_raddr,
  input  logic [xlen-1:0] dmem_rdata,
  output logic            dmem_we,
  output logic [xlen-1:0] dmem_waddr,
  output logic [xlen-1:0] dmem_wdata,
  output logic            ebreak
);

  logic [xlen-1:0] pc;
  logic [xlen-1:0] pc_plus4;
  logic            is_ebreak;

  reg_addr_t       rs1;
  reg_addr_t       rs2;
  reg_addr_t       rd;
  logic            reg_write;
  logic            mem_write;
  alu_a_sel_t      alu_a_sel;
  logic            alu_b_imm;
  alu_op_t         alu_op;
  res_sel_t        res_sel;
  logic            is_branch;
  logic            is_jump;
  logic            jump_reg;
  logic [2:0]      funct3;
  logic [xlen-1:0] imm;

  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] alu_result;
  logic            pc_redirect;
  logic [xlen-1:0] target;
  logic [xlen-1:0] rd_data;

  // ----------------------------------------
  // Fetch and PC
  // ----------------------------------------
  assign imem_raddr = pc;
  assign pc_plus4   = pc + 32'd4;
  assign is_ebreak  = (imem_rdata == instr_ebreak);

  // PC sticks on EBREAK so the core stays halted
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= reset_pc;
    end else if (!is_ebreak) begin
      pc <= pc_redirect ? target : pc_plus4;
    end
  end

  rv_decode u_decode (
    .instr     (imem_rdata),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .reg_write (reg_write),
    .mem_write (mem_write),
    .alu_a_sel (alu_a_sel),
    .alu_b_imm (alu_b_imm),
    .alu_op    (alu_op),
    .res_sel   (res_sel),
    .is_branch (is_branch),
    .is_jump   (is_jump),
    .jump_reg  (jump_reg),
    .funct3    (funct3),
    .imm       (imm)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1_addr (rs1),
    .rs1_data (rs1_data),
    .rs2_addr (rs2),
    .rs2_data (rs2_data),
    .rd_en    (reg_write),
    .rd_addr  (rd),
    .rd_data  (rd_data)
  );

  rv_execute u_execute (
    .pc          (pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .alu_a_sel   (alu_a_sel),
    .alu_b_imm   (alu_b_imm),
    .alu_op      (alu_op),
    .is_branch   (is_branch),
    .is_jump     (is_jump),
    .jump_reg    (jump_reg),
    .funct3      (funct3),
    .alu_result  (alu_result),
    .pc_redirect (pc_redirect),
    .target      (target)
  );

  // ----------------------------------------
  // Memory and write-back
  // ----------------------------------------
  assign dmem_raddr = alu_result;
  assign dmem_waddr = alu_result;
  assign dmem_wdata = rs2_data;
  assign dmem_we    = arst_n && mem_write;
  assign ebreak     = arst_n && is_ebreak;

  always_comb begin
    case (res_sel)
      res_load: rd_data = dmem_rdata;
      res_pc4:  rd_data = pc_plus4;
      default:  rd_data = alu_result;
    endcase
  end

endmodule

`default_nettype wire

/* bench/rv_core_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_sva
  import rv_isa_pkg::*;
#(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input logic            clk,
  input logic            arst_n,
  input logic [xlen-1:0] imem_raddr,
  input logic [xlen-1:0] imem_rdata,
  input logic            dmem_we,
  input logic            ebreak
);

  int unsigned fail_count = 0;
  logic        redirect_kind;
  logic        seq_instr;

  // Anything that may leave the PC+4 path
  assign redirect_kind = (imem_rdata[6:0] == op_jal) || (imem_rdata[6:0] == op_jalr) ||
                         (imem_rdata[6:0] == op_branch);
  assign seq_instr     = !redirect_kind && (imem_rdata != instr_ebreak);

  // ----------------------------------------
  // Reset and fetch
  // ----------------------------------------
  a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !dmem_we && !ebreak)
    else begin
      fail_count++;
      $error("dmem_we or ebreak high while in reset");
    end

  a_first_fetch: assert property (@(posedge clk) $rose(arst_n) |-> imem_raddr == reset_pc)
    else begin
      fail_count++;
      $error("first fetch after reset is not at the reset PC");
    end

  a_seq_fetch: assert property (@(posedge clk) disable iff (!arst_n)
      arst_n && seq_instr |=> imem_raddr == $past(imem_raddr) + 32'd4)
    else begin
      fail_count++;
      $error("fetch address did not advance by 4");
    end

  a_aligned: assert property (@(posedge clk) disable iff (!arst_n) imem_raddr[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("fetch address not word aligned");
    end

  // Halt holds for good
  a_halt_hold: assert property (@(posedge clk) disable iff (!arst_n)
      ebreak |=> ebreak && $stable(imem_raddr))
    else begin
      fail_count++;
      $error("ebreak dropped or PC moved after halt");
    end

endmodule

`default_nettype wire

/* bench/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb
  import rv_isa_pkg::*;
();

  localparam int halt_timeout = 2000;
  localparam logic [11:0] poison_addr = 12'h100;

  logic        clk;
  logic        arst_n;
  logic [31:0] imem_raddr;
  logic [31:0] imem_rdata;
  logic [31:0] dmem_raddr;
  logic [31:0] dmem_rdata;
  logic        dmem_we;
  logic [31:0] dmem_waddr;
  logic [31:0] dmem_wdata;
  logic        ebreak;

  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];

  // Program build state and the expected store table
  int          prog_len = 0;
  logic [11:0] slot_next = 12'h200;
  string       exp_name [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int          store_idx = 0;
  int          errors = 0;
  int          late_stores = 0;
  bit          halted = 1'b0;

  string       branch_names [6] = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};
  logic [2:0]  branch_f3s [6] = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};

  rv_core u_rv_core (
    .clk        (clk),
    .arst_n     (arst_n),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .ebreak     (ebreak)
  );

  bind rv_core rv_core_sva #(.reset_pc(reset_pc)) u_sva (.*);

  // ----------------------------------------
  // Clock and memories
  // ----------------------------------------
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  assign imem_rdata = imem[imem_raddr[9:2]];
  assign dmem_rdata = dmem[dmem_raddr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_waddr[9:2]] <= dmem_wdata;
    end
  end

  // ----------------------------------------
  // Instruction encoders
  // ----------------------------------------
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  // Reference branch decision
  function automatic bit branch_ref(input logic [2:0] f3, input logic [31:0] a,
      input logic [31:0] b);
    case (f3)
      f3_beq:  return a == b;
      f3_bne:  return a != b;
      f3_blt:  return $signed(a) < $signed(b);
      f3_bge:  return $signed(a) >= $signed(b);
      f3_bltu: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // ----------------------------------------
  // Program builders
  // ----------------------------------------
  task automatic emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  // LUI/ADDI pair, upper part rounded for the signed low half
  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    emit(u_type(upper[31:12], rd, op_lui));
    emit(i_type(value[11:0], rd, 3'b000, rd, op_imm));
  endtask

  task automatic store_expect(input string name, input logic [4:0] rs, input logic [31:0] value);
    emit(s_type(slot_next, rs, 5'd0));
    exp_name.push_back(name);
    exp_addr.push_back({20'h0, slot_next});
    exp_data.push_back(value);
    slot_next += 12'd4;
  endtask

  task automatic poison_store();
    emit(s_type(poison_addr, 5'd5, 5'd0));
  endtask

  task automatic reg_op(input string name, input logic [6:0] f7, input logic [2:0] f3,
      input logic [31:0] expected);
    emit(r_type(f7, 5'd2, 5'd1, f3, 5'd3));
    store_expect(name, 5'd3, expected);
  endtask

  task automatic imm_op(input string name, input logic [11:0] imm, input logic [2:0] f3,
      input logic [31:0] expected);
    emit(i_type(imm, 5'd1, f3, 5'd3, op_imm));
    store_expect(name, 5'd3, expected);
  endtask

  // Operands in x1 and x2, every result goes through x3
  task automatic alu_round(input string tag, input logic [31:0] a, input logic [31:0] b);
    logic [11:0] imm;
    logic [31:0] immx;
    logic [4:0]  sh;
    imm  = 12'($urandom);
    immx = {{20{imm[11]}}, imm};
    // Nonzero so that SRAI and SRLI differ on a negative value
    sh   = 5'($urandom) | 5'd1;
    load_const(5'd1, a);
    load_const(5'd2, b);
    reg_op({"add", tag}, 7'h00, f3_add, a + b);
    reg_op({"sub", tag}, 7'h20, f3_add, a - b);
    reg_op({"sll", tag}, 7'h00, f3_sll, a << b[4:0]);
    reg_op({"slt", tag}, 7'h00, f3_slt, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    reg_op({"sltu", tag}, 7'h00, f3_sltu, (a < b) ? 32'd1 : 32'd0);
    reg_op({"xor", tag}, 7'h00, f3_xor, a ^ b);
    reg_op({"srl", tag}, 7'h00, f3_sr, a >> b[4:0]);
    reg_op({"sra", tag}, 7'h20, f3_sr, 32'($signed(a) >>> b[4:0]));
    reg_op({"or", tag}, 7'h00, f3_or, a | b);
    reg_op({"and", tag}, 7'h00, f3_and, a & b);
    imm_op({"addi", tag}, imm, f3_add, a + immx);
    imm_op({"slti", tag}, imm, f3_slt, ($signed(a) < $signed(immx)) ? 32'd1 : 32'd0);
    imm_op({"sltiu", tag}, imm, f3_sltu, (a < immx) ? 32'd1 : 32'd0);
    imm_op({"xori", tag}, imm, f3_xor, a ^ immx);
    imm_op({"ori", tag}, imm, f3_or, a | immx);
    imm_op({"andi", tag}, imm, f3_and, a & immx);
    imm_op({"slli", tag}, {7'h00, sh}, f3_sll, a << sh);
    imm_op({"srli", tag}, {7'h00, sh}, f3_sr, a >> sh);
    imm_op({"srai", tag}, {7'h20, sh}, f3_sr, 32'($signed(a) >>> sh));
  endtask

  // Taken skips the poison store, not taken stores x10
  task automatic branch_case(input string name, input logic [2:0] f3, input logic [4:0] rs1,
      input logic [4:0] rs2, input logic [31:0] a, input logic [31:0] b,
      input logic [31:0] x10_val);
    emit(b_type(13'd8, rs2, rs1, f3));
    if (branch_ref(f3, a, b)) begin
      poison_store();
    end else begin
      store_expect(name, 5'd10, x10_val);
    end
  endtask

  // ----------------------------------------
  // Store checks and halt watch
  // ----------------------------------------
  task automatic check_store();
    if (store_idx >= exp_addr.size()) begin
      errors++;
      $display("Unexpected store of %h to %h after the last expected store",
               dmem_wdata, dmem_waddr);
    end else begin
      assert (dmem_waddr == exp_addr[store_idx]) else begin
        errors++;
        $display("ERR %s address: expected %h, actual %h",
                 exp_name[store_idx], exp_addr[store_idx], dmem_waddr);
      end
      assert (dmem_wdata == exp_data[store_idx]) else begin
        errors++;
        $display("ERR %s data: expected %h, actual %h",
                 exp_name[store_idx], exp_data[store_idx], dmem_wdata);
      end
      store_idx++;
    end
  endtask

  always @(negedge clk) begin
    if (arst_n && dmem_we) begin
      if (halted) begin
        late_stores++;
      end else begin
        check_store();
      end
    end
    if (ebreak) begin
      halted = 1'b1;
    end
  end

  // ----------------------------------------
  // Program build and run
  // ----------------------------------------
  initial begin
    logic [31:0] pc_now;
    logic [31:0] ls_val;
    logic [31:0] n;
    logic [31:0] p;
    logic [19:0] imm20;
    logic [31:0] first_word;
    int          cycles;
    int          total;

    arst_n = 1'b0;
    void'($urandom(32'h69f3));
    for (int i = 0; i < 256; i++) begin
      imem[i] = i_type(12'(i), 5'd0, 3'b000, 5'd0, op_imm);
      dmem[i] = 32'hc0de_0000 | i;
    end

    // A store sits at the reset PC, x0 is zero out of reset
    store_expect("reset_sw", 5'd0, 32'd0);

    alu_round("_rnd", $urandom, $urandom);
    // Opposite signs, A negative, shift amount nonzero
    alu_round("_mix", $urandom | 32'h8000_0000, ($urandom & 32'h7fff_ffff) | 32'h1);

    imm20 = 20'($urandom);
    emit(u_type(imm20, 5'd3, op_lui));
    store_expect("lui", 5'd3, {imm20, 12'h000});
    pc_now = 32'(prog_len * 4);
    emit(u_type(imm20, 5'd3, op_auipc));
    store_expect("auipc", 5'd3, pc_now + {imm20, 12'h000});

    // Word round trip through memory
    ls_val = $urandom;
    load_const(5'd1, ls_val);
    pc_now = {20'h0, slot_next};
    store_expect("sw", 5'd1, ls_val);
    emit(i_type(pc_now[11:0], 5'd0, 3'b010, 5'd4, op_load));
    emit(i_type(12'd1, 5'd4, 3'b000, 5'd4, op_imm));
    store_expect("lw_addi", 5'd4, ls_val + 32'd1);

    n = $urandom | 32'h8000_0000;
    p = $urandom & 32'h7fff_ffff;
    load_const(5'd5, 32'hdead_beef);
    load_const(5'd10, n);
    load_const(5'd11, p);
    for (int k = 0; k < 6; k++) begin
      branch_case({branch_names[k], "_eq"}, branch_f3s[k], 5'd10, 5'd10, n, n, n);
      branch_case({branch_names[k], "_np"}, branch_f3s[k], 5'd10, 5'd11, n, p, n);
      branch_case({branch_names[k], "_pn"}, branch_f3s[k], 5'd11, 5'd10, p, n, n);
    end

    pc_now = 32'(prog_len * 4);
    emit(j_type(21'd8, 5'd7));
    poison_store();
    store_expect("jal_link", 5'd7, pc_now + 32'd4);

    // JALR at pc_now, base plus one is odd
    pc_now = 32'(prog_len * 4) + 32'd8;
    load_const(5'd8, pc_now + 32'd8);
    emit(i_type(12'd1, 5'd8, 3'b000, 5'd9, op_jalr));
    poison_store();
    store_expect("jalr_link", 5'd9, pc_now + 32'd4);
    emit(instr_ebreak);

    // EBREAK and then the first store at the reset PC while in reset
    first_word = imem[0];
    imem[0] = instr_ebreak;
    repeat (4) @(posedge clk);
    imem[0] <= first_word;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;

    cycles = 0;
    while (!ebreak && cycles < halt_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!ebreak) begin
      errors++;
      $display("Timeout: ebreak did not rise within %0d cycles", halt_timeout);
    end else begin
      // Window for the halt hold checks
      repeat (16) @(negedge clk);
    end

    assert (store_idx == exp_addr.size()) else begin
      errors++;
      $display("Missing stores: only %0d of %0d expected stores were seen",
               store_idx, exp_addr.size());
    end

    total = errors + late_stores + int'(u_rv_core.u_sva.fail_count);
    $display("Errors: %0d store, %0d after halt, %0d assertion, %0d total",
             errors, late_stores, u_rv_core.u_sva.fail_count, total);
    if (total == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rv_core.f */
src/rv_isa_pkg.sv
src/rv_core_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_core.sv
bench/rv_core_sva.sv
bench/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  # Packages first, then the core from the leaves up
  - src/rv_isa_pkg.sv
  - src/rv_core_pkg.sv
  - src/rv_decode.sv
  - src/rv_regfile.sv
  - src/rv_execute.sv
  - src/rv_core.sv

  # Testbench and bound assertions
  - target: test
    files:
      - bench/rv_core_sva.sv
      - bench/rv_core_tb.sv
